// ==== common/mldsa_params.svh ====
// ML-DSA arithmetic parameters

`ifndef MLDSA_PARAMS_SVH
`define MLDSA_PARAMS_SVH

// --------------------
// Widths
// --------------------

// One coefficient, always below q
`define MLDSA_REG_SIZE 23

// Full product of two coefficients
`define MLDSA_PROD_SIZE 46

// --------------------
// Prime
// --------------------

// q = 2^23 - 2^13 + 1, the folding reducer relies on this form
`define MLDSA_Q 23'd8380417

`endif

// ==== common/mldsa_pkg.sv ====
// ML-DSA datapath types

`include "mldsa_params.svh"

package mldsa_pkg;

    // One coefficient in the range 0 to q-1
    typedef logic [`MLDSA_REG_SIZE-1:0] coeff_t;

    // --------------------
    // Product limbs
    // --------------------

    // Slices used by the folding reducer, MSB first
    // 2^23 = 2^13 - 1 mod q, so each limb above bit 23 folds down
    typedef struct packed {
        // Bits 45..43
        logic [2:0]  top3;
        // Bits 42..33
        logic [9:0]  mid_hi;
        // Bits 32..23
        logic [9:0]  mid_lo;
        // Bits 22..13
        logic [9:0]  low_hi;
        // Bits 12..0, passed through untouched
        logic [12:0] low13;
    } prod_limbs_t;

    // Same product word seen flat by the multiplier
    // and as limbs by the reducer
    typedef union packed {
        logic [`MLDSA_PROD_SIZE-1:0] flat;
        prod_limbs_t                 limbs;
    } prod_u;

endpackage

// ==== files.f ====
+incdir+common
common/mldsa_pkg.sv
ntt_mult_reduction/ntt_add_sub_mod.sv
ntt_mult_reduction/ntt_special_adder.sv
ntt_mult_reduction/ntt_mult_reduction.sv
rtl/ntt_mult_stage.sv
rtl/ntt_mod_mult.sv
sim/tb_ntt_mod_mult.sv

// ==== ntt_mult_reduction/ntt_add_sub_mod.sv ====
// Registered modular adder and subtractor

`timescale 1ns/1ps

`include "mldsa_params.svh"

module ntt_add_sub_mod (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  logic               sub_i,
    input  mldsa_pkg::coeff_t  opa_i,
    input  mldsa_pkg::coeff_t  opb_i,
    output mldsa_pkg::coeff_t  res_o
);

    // Raw and corrected sums, one extra bit for carry or borrow
    logic [`MLDSA_REG_SIZE:0]   sum_raw;
    logic [`MLDSA_REG_SIZE+1:0] sum_corr;
    logic [`MLDSA_REG_SIZE:0]   diff_raw;
    logic [`MLDSA_REG_SIZE:0]   diff_corr;
    mldsa_pkg::coeff_t          res_d;

    // --------------------
    // Datapath
    // --------------------

    always_comb begin
        sum_raw   = {1'b0, opa_i} + {1'b0, opb_i};
        // Borrow here means the sum was already below q
        sum_corr  = {1'b0, sum_raw} - {2'b0, `MLDSA_Q};
        diff_raw  = {1'b0, opa_i} - {1'b0, opb_i};
        // Wrap a negative difference back into range
        diff_corr = diff_raw + {1'b0, `MLDSA_Q};

        if (sub_i) begin
            // Borrow set, so add q back
            res_d = diff_raw[`MLDSA_REG_SIZE] ? diff_corr[`MLDSA_REG_SIZE-1:0]
                                              : diff_raw[`MLDSA_REG_SIZE-1:0];
        end else begin
            // No borrow, so sum was at least q
            res_d = sum_corr[`MLDSA_REG_SIZE+1] ? sum_raw[`MLDSA_REG_SIZE-1:0]
                                                : sum_corr[`MLDSA_REG_SIZE-1:0];
        end
    end

    // Result register
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            res_o <= '0;
        end else begin
            res_o <= res_d;
        end
    end

endmodule

// ==== ntt_mult_reduction/ntt_mult_reduction.sv ====
// Folding reduction mod q

`timescale 1ns/1ps

`include "mldsa_params.svh"

module ntt_mult_reduction (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  mldsa_pkg::prod_u   prod_i,
    input  logic               valid_i,
    output mldsa_pkg::coeff_t  res_o,
    output logic               ready_o
);

    // Flopped product
    mldsa_pkg::prod_u  prod_q;

    // Fold terms
    logic [11:0]       c_sum;
    logic [10:0]       d_fold;
    logic [13:0]       f_corr;

    // Stage results
    mldsa_pkg::coeff_t e_res;
    mldsa_pkg::coeff_t g_res;
    mldsa_pkg::coeff_t sub_res;

    // Valid tracking, one bit per reducer cycle
    logic [3:0]        valid_sr;

    // --------------------
    // Input flop
    // --------------------

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            prod_q <= '0;
        end else begin
            prod_q <= prod_i;
        end
    end

    // --------------------
    // Fold logic
    // --------------------

    always_comb begin
        // Upper limbs folded onto bit 13
        c_sum  = {9'd0, prod_q.limbs.top3} +
                 {2'd0, prod_q.limbs.mid_hi} +
                 {2'd0, prod_q.limbs.mid_lo} +
                 {2'd0, prod_q.limbs.low_hi};
        // Carry out of c folded once more
        d_fold = {9'd0, c_sum[11:10]} + {1'd0, c_sum[9:0]};
        // Correction for the -1 part of each fold
        f_corr = {11'd0, prod_q.limbs.top3} +
                 {1'd0, prod_q.limbs.top3, prod_q.limbs.mid_hi} +
                 {12'd0, c_sum[11:10]};
    end

    // e = f + z[45:23] mod q
    ntt_add_sub_mod mod_add_e_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (1'b0),
        .opa_i     ({{(`MLDSA_REG_SIZE-14){1'b0}}, f_corr}),
        .opb_i     ({prod_q.limbs.top3, prod_q.limbs.mid_hi, prod_q.limbs.mid_lo}),
        .res_o     (e_res)
    );

    // g = {d, z[12:0]} reduced once
    ntt_special_adder mod_add_g_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .fold_i    (d_fold),
        .low_i     (prod_q.limbs.low13),
        .res_o     (g_res)
    );

    // --------------------
    // Final combine
    // --------------------

    // Result is g - e mod q
    ntt_add_sub_mod mod_sub_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (1'b1),
        .opa_i     (g_res),
        .opb_i     (e_res),
        .res_o     (sub_res)
    );

    // Output flop and valid pipe
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            res_o    <= '0;
            valid_sr <= '0;
        end else begin
            res_o    <= sub_res;
            valid_sr <= {valid_sr[2:0], valid_i};
        end
    end

    assign ready_o = valid_sr[3];

endmodule

// ==== ntt_mult_reduction/ntt_special_adder.sv ====
// Fold and low slice combiner

`timescale 1ns/1ps

`include "mldsa_params.svh"

module ntt_special_adder (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  logic [10:0]        fold_i,
    input  logic [12:0]        low_i,
    output mldsa_pkg::coeff_t  res_o
);

    // Fold sum sits directly above the 13 low bits
    logic [`MLDSA_REG_SIZE:0]   joined;
    logic [`MLDSA_REG_SIZE+1:0] joined_corr;
    mldsa_pkg::coeff_t          res_d;

    // --------------------
    // Single reduction
    // --------------------

    always_comb begin
        joined      = {fold_i, low_i};
        joined_corr = {1'b0, joined} - {2'b0, `MLDSA_Q};
        // Value stays below 2q, so one subtract is enough
        if (joined_corr[`MLDSA_REG_SIZE+1]) begin
            res_d = joined[`MLDSA_REG_SIZE-1:0];
        end else begin
            res_d = joined_corr[`MLDSA_REG_SIZE-1:0];
        end
    end

    // Result register
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            res_o <= '0;
        end else begin
            res_o <= res_d;
        end
    end

endmodule

// ==== rtl/ntt_mod_mult.sv ====
// ML-DSA modular multiplier top

`timescale 1ns/1ps

`include "mldsa_params.svh"

module ntt_mod_mult (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize_i,
    input  logic                       valid_i,
    input  logic [`MLDSA_REG_SIZE-1:0] opa_i,
    input  logic [`MLDSA_REG_SIZE-1:0] opb_i,
    output logic [`MLDSA_REG_SIZE-1:0] res_o,
    output logic                       valid_o
);

    // Product word between the stages
    logic [`MLDSA_PROD_SIZE-1:0] prod;
    logic                        prod_valid;

    // --------------------
    // Multiply
    // --------------------

    // Two cycles, operands then product
    ntt_mult_stage mult_stage_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .valid_i   (valid_i),
        .opa_i     (opa_i),
        .opb_i     (opb_i),
        .prod_o    (prod),
        .valid_o   (prod_valid)
    );

    // --------------------
    // Reduce
    // --------------------

    // Four more cycles, result five edges after input
    ntt_mult_reduction mult_reduction_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .prod_i    (prod),
        .valid_i   (prod_valid),
        .res_o     (res_o),
        .ready_o   (valid_o)
    );

endmodule

// ==== rtl/ntt_mult_stage.sv ====
// NTT coefficient multiply stage

`timescale 1ns/1ps

`include "mldsa_params.svh"

module ntt_mult_stage (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  logic               valid_i,
    input  mldsa_pkg::coeff_t  opa_i,
    input  mldsa_pkg::coeff_t  opb_i,
    output mldsa_pkg::prod_u   prod_o,
    output logic               valid_o
);

    // Operand register stage
    mldsa_pkg::coeff_t opa_q;
    mldsa_pkg::coeff_t opb_q;
    logic              op_valid_q;

    // --------------------
    // Operand capture
    // --------------------

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            opa_q      <= '0;
            opb_q      <= '0;
            op_valid_q <= 1'b0;
        end else begin
            opa_q      <= opa_i;
            opb_q      <= opb_i;
            op_valid_q <= valid_i;
        end
    end

    // --------------------
    // Product register
    // --------------------

    // Full 46-bit product, written through the flat view
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            prod_o.flat <= '0;
            valid_o     <= 1'b0;
        end else begin
            prod_o.flat <= {{`MLDSA_REG_SIZE{1'b0}}, opa_q} *
                           {{`MLDSA_REG_SIZE{1'b0}}, opb_q};
            valid_o     <= op_valid_q;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the modular multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
    -f files.f \
    --top-module tb_ntt_mod_mult \
    -o tb_ntt_mod_mult

./obj_dir/tb_ntt_mod_mult > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "SIMULATION PASSED" "$LOG"; then
    echo "Run result: pass"
    exit 0
else
    echo "Run result: fail, see $LOG"
    exit 1
fi

// ==== sim/tb_ntt_mod_mult.sv ====
// ML-DSA modular multiplier testbench

`timescale 1ns/1ps

`include "mldsa_params.svh"

module tb_ntt_mod_mult;

    localparam int CLK_PERIOD  = 20;
    localparam int PIPE_LAT    = 5;
    localparam int N_CORNER    = 10;
    localparam int N_RANDOM    = 300;
    localparam int N_GAP_SLOTS = 200;
    localparam int N_ZERO_PRE  = 20;
    localparam int N_ZERO_POST = 20;
    localparam int DRAIN_MAX   = 20;
    localparam int DRAIN_CYC   = DRAIN_MAX + 2;
    localparam int STIM_CYCLES = 5 + N_CORNER + N_RANDOM + N_GAP_SLOTS +
                                 N_ZERO_PRE + 3 + N_ZERO_POST + 4 * DRAIN_CYC;
    localparam int WATCHDOG_CYCLES = STIM_CYCLES + 20;
    localparam logic [`MLDSA_REG_SIZE-1:0] Q = `MLDSA_Q;

    logic                       clk;
    logic                       reset_n;
    logic                       zeroize_i;
    logic                       valid_i;
    logic [`MLDSA_REG_SIZE-1:0] opa_i;
    logic [`MLDSA_REG_SIZE-1:0] opb_i;
    logic [`MLDSA_REG_SIZE-1:0] res_o;
    logic                       valid_o;

    // Scoreboard of expected values and the edges they must appear on
    logic [`MLDSA_REG_SIZE-1:0] exp_val_q[$];
    int                         exp_edge_q[$];
    logic [`MLDSA_REG_SIZE-1:0] cmp_val;
    int                         cmp_edge;
    int                         cycle_cnt = 0;
    string                      cur_test = "reset";
    logic [31:0]                lfsr_state = 32'h63a;
    logic [`MLDSA_REG_SIZE-1:0] op_a;
    logic [`MLDSA_REG_SIZE-1:0] op_b;
    logic [31:0]                gap_bit;
    int                         value_err = 0;
    int                         latency_err = 0;
    int                         unexpected_err = 0;
    int                         state_err = 0;
    int                         missing_err = 0;

    ntt_mod_mult ntt_mod_mult_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .valid_i   (valid_i),
        .opa_i     (opa_i),
        .opb_i     (opb_i),
        .res_o     (res_o),
        .valid_o   (valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Rising edge counter where the first edge is edge 1
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // --------------------
    // Reference and LFSR
    // --------------------

    // Plain (a*b) mod q in 64 bits
    function automatic logic [`MLDSA_REG_SIZE-1:0] mod_mult_ref(
        input logic [`MLDSA_REG_SIZE-1:0] a, input logic [`MLDSA_REG_SIZE-1:0] b);
        logic [63:0] prod;
        logic [63:0] rem;
        prod = {41'd0, a} * {41'd0, b};
        rem  = prod % {41'd0, Q};
        return rem[`MLDSA_REG_SIZE-1:0];
    endfunction

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] bits);
        int k;
        bits = '0;
        for (k = 0; k < n; k++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // 23 random bits folded below q
    task automatic draw_coeff(output logic [`MLDSA_REG_SIZE-1:0] v);
        logic [31:0] raw;
        draw_bits(`MLDSA_REG_SIZE, raw);
        v = raw[`MLDSA_REG_SIZE-1:0];
        if (v >= Q) begin
            v = v - Q;
        end
    endtask

    // --------------------
    // Drive helpers
    // --------------------

    // Starts at a falling edge and returns at the next one
    task automatic drive_pair(input logic [`MLDSA_REG_SIZE-1:0] a,
                              input logic [`MLDSA_REG_SIZE-1:0] b);
        valid_i = 1'b1;
        opa_i   = a;
        opb_i   = b;
        exp_val_q.push_back(mod_mult_ref(a, b));
        exp_edge_q.push_back(cycle_cnt + 1 + PIPE_LAT);
        @(negedge clk);
    endtask

    // Operands move but no strobe
    task automatic drive_skip(input logic [`MLDSA_REG_SIZE-1:0] a,
                              input logic [`MLDSA_REG_SIZE-1:0] b);
        valid_i = 1'b0;
        opa_i   = a;
        opb_i   = b;
        @(negedge clk);
    endtask

    task automatic check_idle(input string what);
        assert (valid_o === 1'b0 && res_o === '0) else begin
            $display(
                "CHECK FAILED %s: expected valid_o=0 res_o=0, actual valid_o=%b res_o=0x%06h",
                what, valid_o, res_o);
            state_err++;
        end
    endtask

    // Wait until every pending pair has produced its result
    task automatic drain_results();
        int n;
        n       = 0;
        valid_i = 1'b0;
        @(posedge clk);
        while (exp_val_q.size() != 0 && n < DRAIN_MAX) begin
            @(posedge clk);
            n++;
        end
        @(negedge clk);
        assert (exp_val_q.size() == 0) else begin
            $display("Results missing in %s: %0d pairs never produced a result",
                     cur_test, exp_val_q.size());
            missing_err++;
            exp_val_q.delete();
            exp_edge_q.delete();
        end
    endtask

    // --------------------
    // Compare process
    // --------------------

    initial begin
        forever begin
            @(negedge clk);
            if (valid_o === 1'b1) begin
                assert (exp_val_q.size() != 0) else begin
                    $display("Unexpected result 0x%06h in %s with no pair pending",
                             res_o, cur_test);
                    unexpected_err++;
                end
                if (exp_val_q.size() != 0) begin
                    cmp_val  = exp_val_q.pop_front();
                    cmp_edge = exp_edge_q.pop_front();
                    assert (res_o === cmp_val) else begin
                        $display("CHECK FAILED %s: expected 0x%06h, actual 0x%06h",
                                 cur_test, cmp_val, res_o);
                        value_err++;
                    end
                    assert (cycle_cnt == cmp_edge) else begin
                        $display("CHECK FAILED %s latency: expected edge %0d, actual edge %0d",
                                 cur_test, cmp_edge, cycle_cnt);
                        latency_err++;
                    end
                end
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------

    initial begin
        reset_n   = 1'b0;
        zeroize_i = 1'b0;
        valid_i   = 1'b0;
        opa_i     = '0;
        opb_i     = '0;

        // Two reset cycles and three quiet cycles after release
        @(negedge clk);
        check_idle("reset");
        @(negedge clk);
        check_idle("reset");
        reset_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle("after reset");
        end

        cur_test = "corner";
        drive_pair(23'd0, 23'd4660123);
        drive_pair(23'd1234567, 23'd0);
        drive_pair(23'd1, Q - 23'd1);
        drive_pair(Q - 23'd1, 23'd1);
        drive_pair(Q - 23'd1, Q - 23'd1);
        drive_pair(Q - 23'd1, Q - 23'd2);
        drive_pair(23'h400000, 23'h400000);
        // Dense bit patterns just below q
        drive_pair(23'h7FDFFF, 23'h7FDFFF);
        drive_pair(23'h7FDFFF, 23'h3FFFFF);
        drive_pair(23'h5FFFFF, 23'h7FDFFF);
        drain_results();

        // One pair per cycle back to back
        cur_test = "random stream";
        for (int i = 0; i < N_RANDOM; i++) begin
            draw_coeff(op_a);
            draw_coeff(op_b);
            drive_pair(op_a, op_b);
        end
        drain_results();

        cur_test = "gaps";
        for (int i = 0; i < N_GAP_SLOTS; i++) begin
            draw_bits(1, gap_bit);
            draw_coeff(op_a);
            draw_coeff(op_b);
            if (gap_bit[0]) begin
                drive_pair(op_a, op_b);
            end else begin
                drive_skip(op_a, op_b);
            end
        end
        drain_results();

        // Zeroize with the pipe full
        cur_test = "zeroize";
        for (int i = 0; i < N_ZERO_PRE; i++) begin
            draw_coeff(op_a);
            draw_coeff(op_b);
            drive_pair(op_a, op_b);
        end
        zeroize_i = 1'b1;
        valid_i   = 1'b0;
        @(posedge clk);
        // Everything in flight is gone
        exp_val_q.delete();
        exp_edge_q.delete();
        @(negedge clk);
        check_idle("zeroize");
        @(negedge clk);
        check_idle("zeroize");
        @(negedge clk);
        check_idle("zeroize");
        zeroize_i = 1'b0;
        for (int i = 0; i < N_ZERO_POST; i++) begin
            draw_coeff(op_a);
            draw_coeff(op_b);
            drive_pair(op_a, op_b);
        end
        drain_results();

        $display("Errors: value=%0d latency=%0d unexpected=%0d state=%0d missing=%0d",
                 value_err, latency_err, unexpected_err, state_err, missing_err);
        if (value_err + latency_err + unexpected_err + state_err + missing_err == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog over the stimulus length plus margin
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
